// File: hw/mac_glue_pkg.sv
// shared constants and types for the system glue around the 68000
// reset hold is shortened for simulation, hardware needs 65535 cen pulses
// floppy sizes are counted in 16-bit words, not bytes
`default_nettype none

package mac_glue_pkg;

	// ==================================================
	// clock-enable sequencer
	// ==================================================

	// eight-phase stage counter
	localparam int STAGE_W = 3;

	// stage numbers at which the enables fire
	localparam logic [STAGE_W-1:0] PHASE_CPU   = 3'd0;
	localparam logic [STAGE_W-1:0] PHASE_CHIP  = 3'd4;
	localparam logic [STAGE_W-1:0] PHASE_LATCH = 3'd7;

	// cen pulses to hold the chipset after the last reset source clears
	localparam int RESET_HOLD_CEN = 64;
	localparam int HOLD_W = $clog2(RESET_HOLD_CEN + 1);

	// ==================================================
	// address map
	// ==================================================

	// chipset byte address, sdram word address, download word address
	localparam int MEM_AW   = 22;
	localparam int SDRAM_AW = 25;
	localparam int DL_AW    = 24;

	// download regions are 21-bit word offsets inside the download bank
	localparam int REGION_AW = 21;
	localparam logic [3:0] DL_BANK   = 4'b0001;
	localparam logic [2:0] CHIP_BANK = 3'b000;

	// floppy images sit right after the os rom
	localparam logic [REGION_AW-1:0] FLOPPY_INT_BASE = 21'h08_0000;
	localparam logic [REGION_AW-1:0] FLOPPY_EXT_BASE = 21'h10_0000;

	// end word address of a complete 800K or 400K image
	localparam logic [DL_AW-1:0] FLOPPY_DS_WORDS = 24'd409600;
	localparam logic [DL_AW-1:0] FLOPPY_SS_WORDS = 24'd204800;

	// lowest address bit of the screen buffer decode
	localparam int SCREEN_LSB = 15;

	// ==================================================
	// types
	// ==================================================

	typedef logic [15:0] word_t;

	// what the host is downloading, value 3 is unused
	typedef enum logic [1:0] {
		DL_ROM        = 2'd0,
		DL_FLOPPY_INT = 2'd1,
		DL_FLOPPY_EXT = 2'd2
	} dl_index_t;

	// configured ram size, in the encoding the address controller expects
	typedef enum logic [1:0] {
		RAM_128K = 2'd0,
		RAM_512K = 2'd1,
		RAM_1M   = 2'd2,
		RAM_4M   = 2'd3
	} ram_size_t;

endpackage

`default_nettype wire

// File: hw/sys_timing.sv
// clock enables and reset sequencing, the phase counter runs on the rising edge
// mem_cfg is sampled only while the reset hold runs, so a change needs a reset
`timescale 1ns/10ps
`default_nettype none

module sys_timing (
	input  wire                     clk_sys,
	input  wire                     n_reset,
	input  wire                     reset_req,
	input  wire                     cpu_reset_out_n,
	input  wire  [1:0]              mem_cfg,
	output logic                    cep,
	output logic                    cen,
	output logic                    cel,
	output logic                    cepix,
	output logic                    chipset_run,
	output mac_glue_pkg::ram_size_t ram_size
);
	import mac_glue_pkg::*;

	logic [STAGE_W-1:0] stage;
	logic [HOLD_W-1:0]  hold_cnt;
	logic               reset_src;

	// ==================================================
	// phase counter
	// ==================================================

	// stage 0 in the first cycle out of reset, then free running
	always_ff @(posedge clk_sys) begin
		if (!n_reset) begin
			stage <= '0;
		end else begin
			stage <= stage + 1'b1;
		end
	end

	// enables decode straight from the stage
	assign cep   = (stage == PHASE_CPU);
	assign cen   = (stage == PHASE_CHIP);
	assign cel   = (stage == PHASE_LATCH);
	// pixel enable every fourth cycle
	assign cepix = (stage[1:0] == 2'b00);

	// ==================================================
	// reset hold
	// ==================================================

	// any of these restarts the hold
	assign reset_src = reset_req || !cpu_reset_out_n;

	always_ff @(posedge clk_sys) begin
		if (!n_reset) begin
			hold_cnt    <= HOLD_W'(RESET_HOLD_CEN);
			chipset_run <= 1'b0;
			ram_size    <= RAM_4M;
		end else if (reset_src) begin
			hold_cnt    <= HOLD_W'(RESET_HOLD_CEN);
			chipset_run <= 1'b0;
		end else if (hold_cnt != '0) begin
			if (cen) begin
				hold_cnt <= hold_cnt - 1'b1;
				// latch memory size, the +1 wraps 3 onto 128K
				ram_size <= ram_size_t'(mem_cfg + 2'd1);
			end
		end else if (cen) begin
			// release on the cen after the last count
			chipset_run <= 1'b1;
		end
	end

endmodule

`default_nettype wire

// File: hw/rom_loader.sv
// pairs host bytes into words, even address is the high byte
// the host must not strobe while ioctl_wait is high
// one word is in flight at a time, it is written in the next download slot
`timescale 1ns/10ps
`default_nettype none

module rom_loader (
	input  wire                              clk_sys,
	input  wire                              n_reset,
	input  wire                              ioctl_download,
	input  wire                              ioctl_wr,
	input  wire  [mac_glue_pkg::DL_AW:0]     ioctl_addr,
	input  wire  [7:0]                       ioctl_data,
	input  var   mac_glue_pkg::dl_index_t    ioctl_index,
	input  wire                              dio_slot,
	output logic                             ioctl_wait,
	output logic                             dl_cycle,
	output logic                             dl_write,
	output logic [mac_glue_pkg::REGION_AW-1:0] dl_addr,
	output mac_glue_pkg::word_t              dl_data
);
	import mac_glue_pkg::*;

	logic [7:0]           hi_byte;
	logic [DL_AW-1:0]     word_addr;
	logic [REGION_AW-1:0] region_addr;
	logic                 odd_wr;
	logic                 slot_d;
	logic                 slot_fall;

	// ==================================================
	// byte pairing and region map
	// ==================================================

	assign odd_wr    = ioctl_wr && ioctl_addr[0];
	// byte address to word address
	assign word_addr = ioctl_addr[DL_AW:1];

	// rom unchanged, floppies offset, wraps at 21 bits
	always_comb begin
		case (ioctl_index)
			DL_ROM:        region_addr = word_addr[REGION_AW-1:0];
			DL_FLOPPY_INT: region_addr = word_addr[REGION_AW-1:0] + FLOPPY_INT_BASE;
			default:       region_addr = word_addr[REGION_AW-1:0] + FLOPPY_EXT_BASE;
		endcase
	end

	// payload, held until the write has gone out
	always_ff @(posedge clk_sys) begin
		if (ioctl_wr && !ioctl_addr[0]) begin
			hi_byte <= ioctl_data;
		end
		if (odd_wr) begin
			dl_data <= {hi_byte, ioctl_data};
			dl_addr <= region_addr;
		end
	end

	// ==================================================
	// wait and write handshake
	// ==================================================

	// a falling slot with a pending write means the sdram took it
	assign slot_fall = slot_d && !dio_slot;

	always_ff @(posedge clk_sys) begin
		if (!n_reset) begin
			slot_d     <= 1'b0;
			ioctl_wait <= 1'b0;
			dl_write   <= 1'b0;
		end else begin
			slot_d <= dio_slot;
			// word complete, stall the host
			if (odd_wr) begin
				ioctl_wait <= 1'b1;
			end
			// write request only changes outside a slot
			if (!dio_slot) begin
				dl_write <= ioctl_wait;
			end
			// done, drop write too so the next slot stays idle
			if (slot_fall && dl_write) begin
				ioctl_wait <= 1'b0;
				dl_write   <= 1'b0;
			end
		end
	end

	// memory side takes the download slot only while downloading
	assign dl_cycle = ioctl_download && dio_slot;

endmodule

`default_nettype wire

// File: hw/floppy_detect.sv
// image size is taken from the last download address when ioctl_download falls
// only 800K and 400K images count as inserted, anything else clears the drive
// bit 0 is the internal drive, bit 1 the external one
`timescale 1ns/10ps
`default_nettype none

module floppy_detect (
	input  wire                           clk_sys,
	input  wire                           n_reset,
	input  wire                           ioctl_download,
	input  var   mac_glue_pkg::dl_index_t ioctl_index,
	input  wire  [mac_glue_pkg::DL_AW:0]  ioctl_addr,
	input  wire  [1:0]                    disk_eject,
	output logic [1:0]                    disk_inserted,
	output logic [1:0]                    disk_double
);
	import mac_glue_pkg::*;

	logic             dl_prev;
	logic             dl_done;
	logic [DL_AW-1:0] end_words;
	logic             size_ds;
	logic             size_ss;
	logic [1:0]       drive_sel;

	// end of download, one cycle after the host lets go
	assign dl_done = dl_prev && !ioctl_download;

	// address counts bytes, sizes count words
	assign end_words = ioctl_addr[DL_AW:1];
	assign size_ds   = (end_words == FLOPPY_DS_WORDS);
	assign size_ss   = (end_words == FLOPPY_SS_WORDS);

	// which drive the finished download belongs to
	assign drive_sel[0] = (ioctl_index == DL_FLOPPY_INT);
	assign drive_sel[1] = (ioctl_index == DL_FLOPPY_EXT);

	// ==================================================
	// per-drive image state
	// ==================================================

	always_ff @(posedge clk_sys) begin
		if (!n_reset) begin
			dl_prev       <= 1'b0;
			disk_inserted <= '0;
			disk_double   <= '0;
		end else begin
			dl_prev <= ioctl_download;
			for (int i = 0; i < 2; i++) begin
				if (dl_done && drive_sel[i]) begin
					disk_inserted[i] <= size_ds || size_ss;
					disk_double[i]   <= size_ds;
				end
				// eject from the os wins over a finishing download
				if (disk_eject[i]) begin
					disk_inserted[i] <= 1'b0;
					disk_double[i]   <= 1'b0;
				end
			end
		end
	end

endmodule

`default_nettype wire

// File: hw/mem_path.sv
// purely combinational, the download side owns the port whenever dl_cycle is high
// chipset strobes are active low, sdram strobes active high
// disk reads are byte wide and come back replicated on both halves
`timescale 1ns/10ps
`default_nettype none

module mem_path (
	input  wire                                  dl_cycle,
	input  wire                                  dl_write,
	input  wire  [mac_glue_pkg::REGION_AW-1:0]   dl_addr,
	input  wire  mac_glue_pkg::word_t            dl_data,
	input  wire  [mac_glue_pkg::MEM_AW-1:0]      mem_addr,
	input  wire                                  rom_oe_n,
	input  wire                                  ram_oe_n,
	input  wire                                  ram_we_n,
	input  wire                                  mem_uds_n,
	input  wire                                  mem_lds_n,
	input  wire  mac_glue_pkg::word_t            mem_wdata,
	input  wire                                  disk_ack_int,
	input  wire                                  disk_ack_ext,
	input  wire  mac_glue_pkg::word_t            sdram_rdata,
	input  var   mac_glue_pkg::ram_size_t        ram_size,
	output logic [mac_glue_pkg::SDRAM_AW-1:0]    sdram_addr,
	output mac_glue_pkg::word_t                  sdram_wdata,
	output logic [1:0]                           sdram_ds,
	output logic                                 sdram_we,
	output logic                                 sdram_oe,
	output mac_glue_pkg::word_t                  chip_rdata,
	output logic [1:0]                           screen_write
);
	import mac_glue_pkg::*;

	word_t disk_byte;
	logic  screen_hit;
	logic  ram_wr;

	// ==================================================
	// port multiplexer
	// ==================================================

	// download bank 0001, chipset gets rom select above its word address
	assign sdram_addr  = dl_cycle ? {DL_BANK, dl_addr}
	                              : {CHIP_BANK, !rom_oe_n, mem_addr[MEM_AW-1:1]};
	assign sdram_wdata = dl_cycle ? dl_data : mem_wdata;
	// downloads always write whole words
	assign sdram_ds    = dl_cycle ? 2'b11 : {!mem_uds_n, !mem_lds_n};
	assign sdram_we    = dl_cycle ? dl_write : !ram_we_n;
	assign sdram_oe    = dl_cycle ? 1'b0 : (!ram_oe_n || !rom_oe_n);

	// even byte address is the high byte
	assign disk_byte = mem_addr[0] ? {sdram_rdata[7:0], sdram_rdata[7:0]}
	                               : {sdram_rdata[15:8], sdram_rdata[15:8]};

	// chipset sees all ones while the slot is lent out
	always_comb begin
		if (dl_cycle) begin
			chip_rdata = '1;
		end else if (disk_ack_int || disk_ack_ext) begin
			chip_rdata = disk_byte;
		end else begin
			chip_rdata = sdram_rdata;
		end
	end

	// ==================================================
	// screen write snoop
	// ==================================================

	// frame buffer sits at the top 32K of ram
	always_comb begin
		case (ram_size)
			RAM_128K: screen_hit = &mem_addr[16:SCREEN_LSB];
			RAM_512K: screen_hit = &mem_addr[18:SCREEN_LSB];
			RAM_1M:   screen_hit = &mem_addr[19:SCREEN_LSB];
			default:  screen_hit = &mem_addr[21:SCREEN_LSB];
		endcase
	end

	assign ram_wr = !ram_we_n && screen_hit;

	// one flag per byte lane
	assign screen_write = {!mem_uds_n && ram_wr, !mem_lds_n && ram_wr};

endmodule

`default_nettype wire

// File: hw/mac_glue_top.sv
// glue around the cpu: clock enables, reset hold, rom and floppy download,
// floppy size detect and the shared sdram port
// cpu, video, sdram controller and host bridge live outside
`timescale 1ns/10ps
`default_nettype none

module mac_glue_top (
	input  wire                                clk_sys,
	input  wire                                n_reset,
	// reset sources and config
	input  wire                                reset_req,
	input  wire                                cpu_reset_out_n,
	input  wire  [1:0]                         mem_cfg,
	// host download
	input  wire                                ioctl_download,
	input  wire                                ioctl_wr,
	input  wire  [mac_glue_pkg::DL_AW:0]       ioctl_addr,
	input  wire  [7:0]                         ioctl_data,
	input  var   mac_glue_pkg::dl_index_t      ioctl_index,
	output logic                               ioctl_wait,
	// chipset side
	input  wire                                dio_slot,
	input  wire  [1:0]                         disk_eject,
	input  wire  [mac_glue_pkg::MEM_AW-1:0]    mem_addr,
	input  wire                                rom_oe_n,
	input  wire                                ram_oe_n,
	input  wire                                ram_we_n,
	input  wire                                mem_uds_n,
	input  wire                                mem_lds_n,
	input  wire  mac_glue_pkg::word_t          mem_wdata,
	input  wire                                disk_ack_int,
	input  wire                                disk_ack_ext,
	input  wire  mac_glue_pkg::word_t          sdram_rdata,
	// timing outputs
	output logic                               cep,
	output logic                               cen,
	output logic                               cel,
	output logic                               cepix,
	output logic                               chipset_run,
	output mac_glue_pkg::ram_size_t            ram_size,
	// floppy state
	output logic [1:0]                         disk_inserted,
	output logic [1:0]                         disk_double,
	// sdram request
	output logic [mac_glue_pkg::SDRAM_AW-1:0]  sdram_addr,
	output mac_glue_pkg::word_t                sdram_wdata,
	output logic [1:0]                         sdram_ds,
	output logic                               sdram_we,
	output logic                               sdram_oe,
	output mac_glue_pkg::word_t                chip_rdata,
	output logic [1:0]                         screen_write
);
	import mac_glue_pkg::*;

	// download word on its way to the sdram
	logic                 dl_cycle;
	logic                 dl_write;
	logic [REGION_AW-1:0] dl_addr;
	word_t                dl_data;

	sys_timing u_sys_timing (
		.clk_sys         (clk_sys),
		.n_reset         (n_reset),
		.reset_req       (reset_req),
		.cpu_reset_out_n (cpu_reset_out_n),
		.mem_cfg         (mem_cfg),
		.cep             (cep),
		.cen             (cen),
		.cel             (cel),
		.cepix           (cepix),
		.chipset_run     (chipset_run),
		.ram_size        (ram_size)
	);

	rom_loader u_rom_loader (
		.clk_sys        (clk_sys),
		.n_reset        (n_reset),
		.ioctl_download (ioctl_download),
		.ioctl_wr       (ioctl_wr),
		.ioctl_addr     (ioctl_addr),
		.ioctl_data     (ioctl_data),
		.ioctl_index    (ioctl_index),
		.dio_slot       (dio_slot),
		.ioctl_wait     (ioctl_wait),
		.dl_cycle       (dl_cycle),
		.dl_write       (dl_write),
		.dl_addr        (dl_addr),
		.dl_data        (dl_data)
	);

	floppy_detect u_floppy_detect (
		.clk_sys        (clk_sys),
		.n_reset        (n_reset),
		.ioctl_download (ioctl_download),
		.ioctl_index    (ioctl_index),
		.ioctl_addr     (ioctl_addr),
		.disk_eject     (disk_eject),
		.disk_inserted  (disk_inserted),
		.disk_double    (disk_double)
	);

	mem_path u_mem_path (
		.dl_cycle     (dl_cycle),
		.dl_write     (dl_write),
		.dl_addr      (dl_addr),
		.dl_data      (dl_data),
		.mem_addr     (mem_addr),
		.rom_oe_n     (rom_oe_n),
		.ram_oe_n     (ram_oe_n),
		.ram_we_n     (ram_we_n),
		.mem_uds_n    (mem_uds_n),
		.mem_lds_n    (mem_lds_n),
		.mem_wdata    (mem_wdata),
		.disk_ack_int (disk_ack_int),
		.disk_ack_ext (disk_ack_ext),
		.sdram_rdata  (sdram_rdata),
		.ram_size     (ram_size),
		.sdram_addr   (sdram_addr),
		.sdram_wdata  (sdram_wdata),
		.sdram_ds     (sdram_ds),
		.sdram_we     (sdram_we),
		.sdram_oe     (sdram_oe),
		.chip_rdata   (chip_rdata),
		.screen_write (screen_write)
	);

endmodule

`default_nettype wire

// File: bench/glue_checker.sv
// watches the DUT pins and compares them with reference models
// samples on the falling edge, the testbench drives on the rising edge
// test_id from the testbench selects which checks are live, 15 ends the run
`timescale 1ns/10ps
`default_nettype none

module glue_checker (
	input  wire                              clk_sys,
	input  wire                              n_reset,
	input  wire  [3:0]                       test_id,
	input  wire                              reset_req,
	input  wire                              cpu_reset_out_n,
	input  wire  [1:0]                       mem_cfg,
	input  wire                              ioctl_download,
	input  wire                              ioctl_wr,
	input  wire  [mac_glue_pkg::DL_AW:0]     ioctl_addr,
	input  wire  [7:0]                       ioctl_data,
	input  wire  [1:0]                       ioctl_index,
	input  wire                              ioctl_wait,
	input  wire                              dio_slot,
	input  wire  [1:0]                       disk_eject,
	input  wire  [mac_glue_pkg::MEM_AW-1:0]  mem_addr,
	input  wire                              rom_oe_n,
	input  wire                              ram_oe_n,
	input  wire                              ram_we_n,
	input  wire                              mem_uds_n,
	input  wire                              mem_lds_n,
	input  wire  [15:0]                      mem_wdata,
	input  wire                              disk_ack_int,
	input  wire                              disk_ack_ext,
	input  wire  [15:0]                      sdram_rdata,
	input  wire                              cep,
	input  wire                              cen,
	input  wire                              cel,
	input  wire                              cepix,
	input  wire                              chipset_run,
	input  wire  [1:0]                       ram_size,
	input  wire  [1:0]                       disk_inserted,
	input  wire  [1:0]                       disk_double,
	input  wire  [mac_glue_pkg::SDRAM_AW-1:0] sdram_addr,
	input  wire  [15:0]                      sdram_wdata,
	input  wire  [1:0]                       sdram_ds,
	input  wire                              sdram_we,
	input  wire                              sdram_oe,
	input  wire  [15:0]                      chip_rdata,
	input  wire  [1:0]                       screen_write,
	output int                               error_count
);
	import mac_glue_pkg::*;

	// chipset_run must rise inside this window of source-free cycles
	localparam int RUN_MIN = 8 * RESET_HOLD_CEN;
	localparam int RUN_MAX = 8 * RESET_HOLD_CEN + 16;

	int          cyc;
	int          since;
	int          checks;
	int          tests;
	int          test_errors;
	logic        src;
	logic        src_prev;
	logic        steady;
	logic        dl_prev;
	logic        we_prev;
	logic        we_now;
	logic        odd_prev;
	logic        wait_prev;
	logic [3:0]  last_id;
	logic [7:0]  hi_byte;
	logic [1:0]  exp_ins;
	logic [1:0]  exp_dbl;
	logic [1:0]  cls;
	logic [1:0]  exp_sw;
	// pending download words as {sdram address, data}
	logic [40:0] pend_q[$];
	logic [40:0] head;

	initial begin
		error_count = 0;
		checks      = 0;
		tests       = 0;
		test_errors = 0;
		last_id     = 4'd0;
	end

	// ==================================================
	// reference models
	// ==================================================

	// {cep, cen, cel, cepix} for a cycle counted from reset release
	function automatic logic [3:0] phase_of_cycle(input int n);
		logic [2:0] s;
		s = 3'(n);
		return {s == PHASE_CPU, s == PHASE_CHIP, s == PHASE_LATCH, s[1:0] == 2'b00};
	endfunction

	// byte address to 21-bit region word address
	function automatic logic [20:0] region_map(input logic [1:0] idx, input logic [24:0] a);
		logic [20:0] w;
		w = a[21:1];
		if (idx == 2'd1) begin
			w = w + FLOPPY_INT_BASE;
		end else if (idx == 2'd2) begin
			w = w + FLOPPY_EXT_BASE;
		end
		return w;
	endfunction

	// {inserted, double} from the last byte address
	function automatic logic [1:0] image_class(input logic [24:0] a);
		logic [23:0] words;
		words = a[24:1];
		return {(words == FLOPPY_DS_WORDS) || (words == FLOPPY_SS_WORDS),
			words == FLOPPY_DS_WORDS};
	endfunction

	// {addr, wdata, ds, we, oe, rdata} on the chipset side
	function automatic logic [60:0] port_mux(input logic [21:0] a, input logic rom_n,
			input logic oe_n, input logic we_n, input logic uds_n, input logic lds_n,
			input logic [15:0] wd, input logic ack, input logic [15:0] rd);
		logic [15:0] rdata;
		if (!ack) begin
			rdata = rd;
		end else if (a[0]) begin
			rdata = {rd[7:0], rd[7:0]};
		end else begin
			rdata = {rd[15:8], rd[15:8]};
		end
		return {3'b000, !rom_n, a[21:1], wd, !uds_n, !lds_n, !we_n, !oe_n || !rom_n, rdata};
	endfunction

	// bits 15 up to the top of ram all set
	function automatic logic screen_hit(input logic [21:0] a, input logic [1:0] size);
		int   top;
		int   i;
		logic hit;
		case (size)
			2'd0:    top = 16;
			2'd1:    top = 18;
			2'd2:    top = 19;
			default: top = 21;
		endcase
		hit = 1'b1;
		for (i = SCREEN_LSB; i <= top; i++) begin
			hit = hit & a[i];
		end
		return hit;
	endfunction

	function automatic string test_name(input logic [3:0] id);
		case (id)
			4'd1:    return "clock enables";
			4'd2:    return "reset hold";
			4'd3:    return "download path";
			4'd4:    return "floppy detect";
			default: return "memory mux";
		endcase
	endfunction

	task automatic check_val(input string what, input logic [63:0] got, input logic [63:0] exp);
		checks++;
		if (got !== exp) begin
			$display("** Error @%0t: %s is %h, expected %h", $time, what, got, exp);
			error_count++;
			test_errors++;
		end
	endtask

	task automatic note_failure(input string msg);
		$display("%0t: %s", $time, msg);
		error_count++;
		test_errors++;
	endtask

	// ==================================================
	// comparisons
	// ==================================================

	always @(negedge clk_sys) begin
		// close the finished test
		if (test_id != last_id) begin
			if (last_id == 4'd3 && pend_q.size() != 0) begin
				note_failure($sformatf("download left %0d words unwritten", pend_q.size()));
				pend_q.delete();
			end
			if (last_id != 4'd0) begin
				$display("test %0d %s: %s, %0d errors", last_id, test_name(last_id),
					(test_errors == 0) ? "ok" : "mismatch", test_errors);
				tests++;
			end
			if (test_id == 4'hf) begin
				$display("summary: %0d tests, %0d checks, %0d errors", tests, checks,
					error_count);
			end
			last_id     = test_id;
			test_errors = 0;
		end

		if (!n_reset) begin
			cyc       = 0;
			since     = 0;
			src_prev  = 1'b1;
			dl_prev   = 1'b0;
			we_prev   = 1'b0;
			odd_prev  = 1'b0;
			wait_prev = 1'b0;
			exp_ins   = 2'b00;
			exp_dbl   = 2'b00;
		end else if (test_id != 4'hf) begin
			if (test_id == 4'd1) begin
				check_val("enables", 64'({cep, cen, cel, cepix}), 64'(phase_of_cycle(cyc)));
			end
			cyc++;

			// reset hold window
			src = reset_req || !cpu_reset_out_n;
			since = src ? 0 : since + 1;
			if (chipset_run && ((src && src_prev) || (since >= 1 && since < RUN_MIN))) begin
				note_failure($sformatf("chipset_run high too early, %0d clear cycles", since));
			end
			if (!chipset_run && since > RUN_MAX) begin
				note_failure($sformatf("chipset_run still low after %0d clear cycles", since));
			end
			steady = chipset_run && !src && !src_prev;
			if (steady) begin
				check_val("ram_size", 64'(ram_size), 64'(2'(mem_cfg + 2'd1)));
			end
			src_prev = src;

			// host stall rises after the odd byte and drops once the word is out
			if (odd_prev) begin
				check_val("ioctl_wait after odd byte", 64'(ioctl_wait), 64'(1'b1));
			end
			if (wait_prev && !ioctl_wait && pend_q.size() != 0) begin
				note_failure("ioctl_wait fell before the word was written");
			end
			odd_prev  = ioctl_wr && ioctl_addr[0];
			wait_prev = ioctl_wait;

			// byte pairing and expected writes
			if (ioctl_wr && !ioctl_addr[0]) begin
				hi_byte = ioctl_data;
			end else if (ioctl_wr) begin
				pend_q.push_back({DL_BANK, region_map(ioctl_index, ioctl_addr), hi_byte,
					ioctl_data});
			end
			we_now = ioctl_download && dio_slot && sdram_we;
			if (we_now && !we_prev) begin
				if (pend_q.size() == 0) begin
					note_failure("download write seen with no word pending");
				end else begin
					head = pend_q.pop_front();
					check_val("download write", 64'({sdram_addr, sdram_wdata}), 64'(head));
					check_val("download strobes", 64'(sdram_ds), 64'(2'b11));
				end
			end
			we_prev = we_now;

			// floppy state, updates land one cycle later
			check_val("floppy state", 64'({disk_inserted, disk_double}),
				64'({exp_ins, exp_dbl}));
			if (dl_prev && !ioctl_download && ioctl_index != 2'd0) begin
				cls = image_class(ioctl_addr);
				exp_ins[ioctl_index - 2'd1] = cls[1];
				exp_dbl[ioctl_index - 2'd1] = cls[0];
			end
			exp_ins = exp_ins & ~disk_eject;
			exp_dbl = exp_dbl & ~disk_eject;
			dl_prev = ioctl_download;

			// chipset side of the port
			if (test_id == 4'd5 && !(ioctl_download && dio_slot)) begin
				check_val("sdram port", 64'({sdram_addr, sdram_wdata, sdram_ds, sdram_we,
					sdram_oe, chip_rdata}), 64'(port_mux(mem_addr, rom_oe_n, ram_oe_n,
					ram_we_n, mem_uds_n, mem_lds_n, mem_wdata,
					disk_ack_int || disk_ack_ext, sdram_rdata)));
				// screen decode follows the configured size once the hold is over
				if (steady) begin
					exp_sw = (!ram_we_n && screen_hit(mem_addr, 2'(mem_cfg + 2'd1)))
						? {!mem_uds_n, !mem_lds_n} : 2'b00;
					check_val("screen_write", 64'(screen_write), 64'(exp_sw));
				end
			end
		end
	end

endmodule

`default_nettype wire

// File: bench/tb_mac_glue.sv
// testbench for the system glue, drives on the rising edge
// the run ends on its own through a cycle limit
`timescale 1ns/10ps
`default_nettype none

module tb_mac_glue;
	import mac_glue_pkg::*;

	localparam int CYCLE_LIMIT = 4000 + 8 * RESET_HOLD_CEN * 3;
	localparam logic [31:0] SEED = 32'h67bd;

	logic        clk_sys;
	logic        n_reset;
	logic        reset_req;
	logic        cpu_reset_out_n;
	logic [1:0]  mem_cfg;
	logic        ioctl_download;
	logic        ioctl_wr;
	logic [24:0] ioctl_addr;
	logic [7:0]  ioctl_data;
	dl_index_t   ioctl_index;
	logic        dio_slot;
	logic [1:0]  disk_eject;
	logic [21:0] mem_addr;
	logic        rom_oe_n;
	logic        ram_oe_n;
	logic        ram_we_n;
	logic        mem_uds_n;
	logic        mem_lds_n;
	word_t       mem_wdata;
	logic        disk_ack_int;
	logic        disk_ack_ext;
	word_t       sdram_rdata;
	logic        ioctl_wait;
	logic        cep;
	logic        cen;
	logic        cel;
	logic        cepix;
	logic        chipset_run;
	ram_size_t   ram_size;
	logic [1:0]  disk_inserted;
	logic [1:0]  disk_double;
	logic [24:0] sdram_addr;
	word_t       sdram_wdata;
	logic [1:0]  sdram_ds;
	logic        sdram_we;
	logic        sdram_oe;
	word_t       chip_rdata;
	logic [1:0]  screen_write;
	logic [3:0]  test_id;
	int          error_count;
	int          cycles;

	mac_glue_top u_mac_glue_top (.*);
	glue_checker u_glue_checker (.*);

	always #5 clk_sys = !clk_sys;

	// download slots come and go at random
	always @(posedge clk_sys) begin
		dio_slot <= ($urandom % 3) == 0;
	end

	always @(posedge clk_sys) begin
		cycles <= cycles + 1;
		if (cycles >= CYCLE_LIMIT) begin
			$display("timeout: the run did not finish within %0d cycles", CYCLE_LIMIT);
			$display("Testbench failed");
			$finish;
		end
	end

	task automatic wait_run();
		do @(negedge clk_sys); while (!chipset_run);
	endtask

	task automatic pulse_reset_req(input int gap);
		@(posedge clk_sys);
		reset_req <= 1'b1;
		mem_cfg   <= 2'($urandom);
		repeat (1 + $urandom % 3) @(posedge clk_sys);
		reset_req <= 1'b0;
		repeat (gap) @(posedge clk_sys);
	endtask

	task automatic send_byte(input logic [24:0] a, input logic [7:0] d);
		@(posedge clk_sys);
		ioctl_wr   <= 1'b1;
		ioctl_addr <= a;
		ioctl_data <= d;
		@(posedge clk_sys);
		ioctl_wr <= 1'b0;
	endtask

	// download with no data, only the final address matters
	task automatic end_download(input int idx, input logic [24:0] a);
		@(posedge clk_sys);
		ioctl_index    <= dl_index_t'(idx);
		ioctl_download <= 1'b1;
		ioctl_addr     <= a;
		repeat (4) @(posedge clk_sys);
		ioctl_download <= 1'b0;
		repeat (3) @(posedge clk_sys);
	endtask

	task automatic pulse_eject(input logic [1:0] m);
		@(posedge clk_sys);
		disk_eject <= m;
		@(posedge clk_sys);
		disk_eject <= 2'b00;
		repeat (2) @(posedge clk_sys);
	endtask

	task automatic random_access();
		logic [21:0] a;
		@(posedge clk_sys);
		a = 22'($urandom);
		// bias toward the screen window of one of the ram sizes
		case ($urandom % 5)
			0:       a = a | 22'h01_8000;
			1:       a = a | 22'h07_8000;
			2:       a = a | 22'h0f_8000;
			3:       a = a | 22'h3f_8000;
			default: ;
		endcase
		mem_addr     <= a;
		rom_oe_n     <= 1'($urandom);
		ram_oe_n     <= 1'($urandom);
		ram_we_n     <= 1'($urandom);
		mem_uds_n    <= 1'($urandom);
		mem_lds_n    <= 1'($urandom);
		mem_wdata    <= 16'($urandom);
		sdram_rdata  <= 16'($urandom);
		disk_ack_int <= ($urandom % 4) == 0;
		disk_ack_ext <= ($urandom % 4) == 0;
	endtask

	initial begin
		int          seed_val;
		int          idx;
		int          w;
		int          base;
		logic [24:0] byte_addr;
		seed_val        = $urandom(SEED);
		clk_sys         = 1'b0;
		n_reset         = 1'b0;
		reset_req       = 1'b0;
		cpu_reset_out_n = 1'b1;
		mem_cfg         = 2'd2;
		ioctl_download  = 1'b0;
		ioctl_wr        = 1'b0;
		ioctl_addr      = '0;
		ioctl_data      = '0;
		ioctl_index     = DL_ROM;
		dio_slot        = 1'b0;
		disk_eject      = 2'b00;
		mem_addr        = '0;
		rom_oe_n        = 1'b1;
		ram_oe_n        = 1'b1;
		ram_we_n        = 1'b1;
		mem_uds_n       = 1'b1;
		mem_lds_n       = 1'b1;
		mem_wdata       = '0;
		disk_ack_int    = 1'b0;
		disk_ack_ext    = 1'b0;
		sdram_rdata     = '0;
		test_id         = 4'd0;
		cycles          = 0;
		repeat (5) @(posedge clk_sys);
		n_reset <= 1'b1;
		test_id <= 4'd1;
		repeat (64) @(posedge clk_sys);

		// reset pulses, then a held cpu reset
		test_id <= 4'd2;
		for (idx = 0; idx < 2; idx++) begin
			repeat (1 + $urandom % 3) pulse_reset_req(1 + $urandom % 40);
			wait_run();
		end
		@(posedge clk_sys);
		cpu_reset_out_n <= 1'b0;
		repeat (100) @(posedge clk_sys);
		cpu_reset_out_n <= 1'b1;
		wait_run();

		// eight words under each download kind
		@(posedge clk_sys);
		test_id <= 4'd3;
		for (idx = 0; idx < 3; idx++) begin
			@(posedge clk_sys);
			ioctl_index    <= dl_index_t'(idx);
			ioctl_download <= 1'b1;
			base = int'($urandom % (1 << 21));
			for (w = 0; w < 8; w++) begin
				byte_addr = 25'((base + w) * 2);
				send_byte(byte_addr, 8'($urandom));
				send_byte(byte_addr | 25'd1, 8'($urandom));
				do @(negedge clk_sys); while (!ioctl_wait);
				do @(negedge clk_sys); while (ioctl_wait);
			end
			@(posedge clk_sys);
			ioctl_download <= 1'b0;
			repeat (2) @(posedge clk_sys);
		end

		// 800K, 400K, odd size, then 800K again on each drive
		test_id <= 4'd4;
		for (idx = 1; idx <= 2; idx++) begin
			end_download(idx, 25'd819200);
			end_download(idx, 25'd409600);
			end_download(idx, 25'd12346);
			end_download(idx, 25'd819200);
		end
		pulse_eject(2'b01);
		pulse_eject(2'b10);

		// chipset accesses under every ram size
		test_id <= 4'd5;
		for (idx = 0; idx < 4; idx++) begin
			@(posedge clk_sys);
			reset_req <= 1'b1;
			mem_cfg   <= 2'(idx + 3);
			@(posedge clk_sys);
			reset_req <= 1'b0;
			wait_run();
			repeat (40) random_access();
		end

		@(posedge clk_sys);
		test_id <= 4'hf;
		repeat (2) @(negedge clk_sys);
		if (error_count == 0) begin
			$display("Testbench passed");
		end else begin
			$display("Testbench failed");
		end
		$finish;
	end

endmodule

`default_nettype wire

// File: mac_glue_top.f
hw/mac_glue_pkg.sv
hw/sys_timing.sv
hw/rom_loader.sv
hw/floppy_detect.sv
hw/mem_path.sv
hw/mac_glue_top.sv
bench/glue_checker.sv
bench/tb_mac_glue.sv

// File: run_sim.sh
#!/usr/bin/env bash
# compile and run the testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing -Wno-fatal \
	-f mac_glue_top.f \
	--top-module tb_mac_glue \
	-o tb_mac_glue

output=$(./obj_dir/tb_mac_glue)
echo "$output"

if echo "$output" | grep -qx "Testbench passed"; then
	exit 0
else
	exit 1
fi
